// File: design/axi_pkg.sv
package axi_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    // beats minus one
    typedef logic [7:0]  len_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  burst_t;

    // log2 of bytes per beat
    localparam size_t SIZE_1 = 3'd0;
    localparam size_t SIZE_2 = 3'd1;
    localparam size_t SIZE_4 = 3'd2;

    localparam burst_t BURST_INCR = 2'd1;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_IFU,
        ARB_LSU
    } arb_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

endpackage

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic           aclk,
    input  logic           areset_n,
    // ifu read
    input  logic           ifu_r_valid_i,
    input  axi_pkg::addr_t ifu_r_addr_i,
    input  axi_pkg::len_t  ifu_r_len_i,
    output logic           ifu_r_ready_o,
    output axi_pkg::data_t ifu_r_data_o,
    output logic           ifu_r_last_o,
    // lsu read
    input  logic           lsu_r_valid_i,
    input  axi_pkg::addr_t lsu_r_addr_i,
    input  axi_pkg::len_t  lsu_r_len_i,
    output logic           lsu_r_ready_o,
    output axi_pkg::data_t lsu_r_data_o,
    output logic           lsu_r_last_o,
    // lsu write
    input  logic           lsu_w_valid_i,
    input  axi_pkg::addr_t lsu_w_addr_i,
    input  axi_pkg::data_t lsu_w_data_i,
    input  axi_pkg::size_t lsu_w_size_i,
    input  axi_pkg::len_t  lsu_w_len_i,
    output logic           lsu_w_ready_o,
    output logic           lsu_w_last_o,
    // bridge side
    output logic           cpu_r_valid_o,
    output axi_pkg::addr_t cpu_r_addr_o,
    output axi_pkg::len_t  cpu_r_len_o,
    output logic           cpu_w_valid_o,
    output axi_pkg::addr_t cpu_w_addr_o,
    output axi_pkg::data_t cpu_w_data_o,
    output axi_pkg::size_t cpu_w_size_o,
    output axi_pkg::len_t  cpu_w_len_o,
    input  logic           cpu_r_ready_i,
    input  axi_pkg::data_t cpu_r_data_i,
    input  logic           cpu_r_last_i,
    input  logic           cpu_w_ready_i,
    input  logic           cpu_w_last_i
);
    import axi_pkg::*;

    arb_state_e state_q;
    logic       ifu_gnt;
    logic       lsu_gnt;
    logic       rd_done;

    assign ifu_gnt = (state_q == ARB_IFU);
    assign lsu_gnt = (state_q == ARB_LSU);
    assign rd_done = cpu_r_ready_i & cpu_r_last_i;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // lsu wins a tie
                    if (lsu_r_valid_i) begin
                        state_q <= ARB_LSU;
                    end else if (ifu_r_valid_i) begin
                        state_q <= ARB_IFU;
                    end
                end
                ARB_IFU: begin
                    // a waiting lsu read goes straight after the burst
                    if (rd_done) begin
                        state_q <= lsu_r_valid_i ? ARB_LSU : ARB_IDLE;
                    end
                end
                ARB_LSU: begin
                    if (rd_done) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // read request mux, nothing while idle
    assign cpu_r_valid_o = (ifu_gnt & ifu_r_valid_i) | (lsu_gnt & lsu_r_valid_i);
    assign cpu_r_addr_o  = ifu_gnt ? ifu_r_addr_i : (lsu_gnt ? lsu_r_addr_i : '0);
    assign cpu_r_len_o   = ifu_gnt ? ifu_r_len_i : (lsu_gnt ? lsu_r_len_i : '0);

    // beats only reach the granted port
    assign ifu_r_ready_o = ifu_gnt & cpu_r_ready_i;
    assign ifu_r_data_o  = ifu_gnt ? cpu_r_data_i : '0;
    assign ifu_r_last_o  = ifu_gnt & cpu_r_last_i;
    assign lsu_r_ready_o = lsu_gnt & cpu_r_ready_i;
    assign lsu_r_data_o  = lsu_gnt ? cpu_r_data_i : '0;
    assign lsu_r_last_o  = lsu_gnt & cpu_r_last_i;

    // only the lsu writes
    assign cpu_w_valid_o = lsu_w_valid_i;
    assign cpu_w_addr_o  = lsu_w_addr_i;
    assign cpu_w_data_o  = lsu_w_data_i;
    assign cpu_w_size_o  = lsu_w_size_i;
    assign cpu_w_len_o   = lsu_w_len_i;
    assign lsu_w_ready_o = cpu_w_ready_i;
    assign lsu_w_last_o  = cpu_w_last_i;

endmodule

// File: design/axi_master_bridge.sv
`timescale 1ns/1ps

module axi_master_bridge (
    input  logic            aclk,
    input  logic            areset_n,
    // cpu read
    input  logic            cpu_r_valid_i,
    input  axi_pkg::addr_t  cpu_r_addr_i,
    input  axi_pkg::len_t   cpu_r_len_i,
    output logic            cpu_r_ready_o,
    output axi_pkg::data_t  cpu_r_data_o,
    output logic            cpu_r_last_o,
    // cpu write
    input  logic            cpu_w_valid_i,
    input  axi_pkg::addr_t  cpu_w_addr_i,
    input  axi_pkg::data_t  cpu_w_data_i,
    input  axi_pkg::size_t  cpu_w_size_i,
    input  axi_pkg::len_t   cpu_w_len_i,
    output logic            cpu_w_ready_o,
    output logic            cpu_w_last_o,
    // ar / r
    output logic            axi_ar_valid_o,
    output axi_pkg::addr_t  axi_ar_addr_o,
    output axi_pkg::len_t   axi_ar_len_o,
    output axi_pkg::size_t  axi_ar_size_o,
    output axi_pkg::burst_t axi_ar_burst_o,
    input  logic            axi_ar_ready_i,
    output logic            axi_r_ready_o,
    input  logic            axi_r_valid_i,
    input  axi_pkg::data_t  axi_r_data_i,
    input  logic            axi_r_last_i,
    // aw / w / b
    output logic            axi_aw_valid_o,
    output axi_pkg::addr_t  axi_aw_addr_o,
    output axi_pkg::len_t   axi_aw_len_o,
    output axi_pkg::size_t  axi_aw_size_o,
    output axi_pkg::burst_t axi_aw_burst_o,
    input  logic            axi_aw_ready_i,
    output logic            axi_w_valid_o,
    output axi_pkg::data_t  axi_w_data_o,
    output axi_pkg::strb_t  axi_w_strb_o,
    output logic            axi_w_last_o,
    input  logic            axi_w_ready_i,
    output logic            axi_b_ready_o,
    input  logic            axi_b_valid_i
);
    import axi_pkg::*;

    rd_state_e rd_state_q;
    wr_state_e wr_state_q;
    addr_t     rd_addr_q;
    len_t      rd_len_q;
    addr_t     wr_addr_q;
    len_t      wr_len_q;
    size_t     wr_size_q;
    len_t      wr_beat_q;
    logic      w_hs;

    // read side
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            rd_state_q <= RD_IDLE;
        end else begin
            case (rd_state_q)
                RD_IDLE: if (cpu_r_valid_i) rd_state_q <= RD_ADDR;
                RD_ADDR: if (axi_ar_ready_i) rd_state_q <= RD_DATA;
                RD_DATA: if (axi_r_valid_i && axi_r_last_i) rd_state_q <= RD_IDLE;
                default: rd_state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_state_q == RD_IDLE && cpu_r_valid_i) begin
            rd_addr_q <= cpu_r_addr_i;
            rd_len_q  <= cpu_r_len_i;
        end
    end

    assign axi_ar_valid_o = (rd_state_q == RD_ADDR);
    assign axi_ar_addr_o  = rd_addr_q;
    assign axi_ar_len_o   = rd_len_q;
    assign axi_ar_size_o  = SIZE_4;
    assign axi_ar_burst_o = BURST_INCR;

    // cpu cannot stall a beat
    assign axi_r_ready_o = (rd_state_q == RD_DATA);
    assign cpu_r_ready_o = axi_r_ready_o & axi_r_valid_i;
    assign cpu_r_data_o  = axi_r_data_i;
    assign cpu_r_last_o  = cpu_r_ready_o & axi_r_last_i;

    // write side
    assign w_hs = axi_w_valid_o & axi_w_ready_i;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            wr_state_q <= WR_IDLE;
            wr_beat_q  <= '0;
        end else begin
            case (wr_state_q)
                WR_IDLE: if (cpu_w_valid_i) wr_state_q <= WR_ADDR;
                WR_ADDR: begin
                    if (axi_aw_ready_i) begin
                        wr_state_q <= WR_DATA;
                        wr_beat_q  <= '0;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        wr_beat_q <= wr_beat_q + 8'd1;
                        if (axi_w_last_o) begin
                            wr_state_q <= WR_RESP;
                        end
                    end
                end
                WR_RESP: if (axi_b_valid_i) wr_state_q <= WR_IDLE;
                default: wr_state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_state_q == WR_IDLE && cpu_w_valid_i) begin
            wr_addr_q <= cpu_w_addr_i;
            wr_len_q  <= cpu_w_len_i;
            wr_size_q <= cpu_w_size_i;
        end
    end

    assign axi_aw_valid_o = (wr_state_q == WR_ADDR);
    assign axi_aw_addr_o  = wr_addr_q;
    assign axi_aw_len_o   = wr_len_q;
    assign axi_aw_size_o  = wr_size_q;
    assign axi_aw_burst_o = BURST_INCR;

    // lsu already steers data onto its byte lanes
    assign axi_w_valid_o = (wr_state_q == WR_DATA);
    assign axi_w_data_o  = cpu_w_data_i;
    assign axi_w_last_o  = (wr_beat_q == wr_len_q);

    always_comb begin
        case (wr_size_q)
            SIZE_1:  axi_w_strb_o = strb_t'(4'b0001 << wr_addr_q[1:0]);
            SIZE_2:  axi_w_strb_o = strb_t'(4'b0011 << {wr_addr_q[1], 1'b0});
            default: axi_w_strb_o = 4'b1111;
        endcase
    end

    assign axi_b_ready_o = (wr_state_q == WR_RESP);
    assign cpu_w_ready_o = w_hs;
    assign cpu_w_last_o  = axi_b_ready_o & axi_b_valid_i;

endmodule

// File: design/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave #(
    parameter int MEM_DEPTH_WORDS = 1024
) (
    input  logic            aclk,
    input  logic            areset_n,
    input  logic            axi_ar_valid_i,
    input  axi_pkg::addr_t  axi_ar_addr_i,
    input  axi_pkg::len_t   axi_ar_len_i,
    input  axi_pkg::size_t  axi_ar_size_i,
    input  axi_pkg::burst_t axi_ar_burst_i,
    output logic            axi_ar_ready_o,
    input  logic            axi_r_ready_i,
    output logic            axi_r_valid_o,
    output axi_pkg::data_t  axi_r_data_o,
    output logic            axi_r_last_o,
    input  logic            axi_aw_valid_i,
    input  axi_pkg::addr_t  axi_aw_addr_i,
    input  axi_pkg::len_t   axi_aw_len_i,
    input  axi_pkg::size_t  axi_aw_size_i,
    input  axi_pkg::burst_t axi_aw_burst_i,
    output logic            axi_aw_ready_o,
    input  logic            axi_w_valid_i,
    input  axi_pkg::data_t  axi_w_data_i,
    input  axi_pkg::strb_t  axi_w_strb_i,
    input  logic            axi_w_last_i,
    output logic            axi_w_ready_o,
    input  logic            axi_b_ready_i,
    output logic            axi_b_valid_o
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(MEM_DEPTH_WORDS);

    data_t            mem [MEM_DEPTH_WORDS];
    logic             rd_active_q;
    addr_t            rd_addr_q;
    len_t             rd_cnt_q;
    size_t            rd_size_q;
    burst_t           rd_burst_q;
    logic             wr_active_q;
    logic             b_valid_q;
    addr_t            wr_addr_q;
    len_t             wr_cnt_q;
    size_t            wr_size_q;
    burst_t           wr_burst_q;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             r_hs;
    logic             w_hs;
    logic             w_final;

    // word index wraps modulo the depth
    assign rd_idx = rd_addr_q[IDX_W+1:2];
    assign wr_idx = wr_addr_q[IDX_W+1:2];

    // read engine
    assign axi_ar_ready_o = ~rd_active_q;
    assign axi_r_valid_o  = rd_active_q;
    assign axi_r_data_o   = mem[rd_idx];
    assign axi_r_last_o   = (rd_cnt_q == '0);
    assign r_hs           = axi_r_valid_o & axi_r_ready_i;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            rd_active_q <= 1'b0;
        end else if (axi_ar_valid_i && axi_ar_ready_o) begin
            rd_active_q <= 1'b1;
        end else if (r_hs && axi_r_last_o) begin
            rd_active_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (axi_ar_valid_i && axi_ar_ready_o) begin
            rd_addr_q  <= axi_ar_addr_i;
            rd_cnt_q   <= axi_ar_len_i;
            rd_size_q  <= axi_ar_size_i;
            rd_burst_q <= axi_ar_burst_i;
        end else if (r_hs) begin
            rd_cnt_q <= rd_cnt_q - 8'd1;
            if (rd_burst_q == BURST_INCR) begin
                rd_addr_q <= rd_addr_q + (addr_t'(1) << rd_size_q);
            end
        end
    end

    // write engine, one burst and its response at a time
    assign axi_aw_ready_o = ~wr_active_q & ~b_valid_q;
    assign axi_w_ready_o  = wr_active_q;
    assign axi_b_valid_o  = b_valid_q;
    assign w_hs           = axi_w_valid_i & axi_w_ready_o;
    // stop on whichever marks the final beat first
    assign w_final        = axi_w_last_i | (wr_cnt_q == '0);

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            wr_active_q <= 1'b0;
            b_valid_q   <= 1'b0;
        end else begin
            if (axi_aw_valid_i && axi_aw_ready_o) begin
                wr_active_q <= 1'b1;
            end else if (w_hs && w_final) begin
                wr_active_q <= 1'b0;
                b_valid_q   <= 1'b1;
            end
            if (b_valid_q && axi_b_ready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (axi_aw_valid_i && axi_aw_ready_o) begin
            wr_addr_q  <= axi_aw_addr_i;
            wr_cnt_q   <= axi_aw_len_i;
            wr_size_q  <= axi_aw_size_i;
            wr_burst_q <= axi_aw_burst_i;
        end else if (w_hs) begin
            wr_cnt_q <= wr_cnt_q - 8'd1;
            if (wr_burst_q == BURST_INCR) begin
                wr_addr_q <= wr_addr_q + (addr_t'(1) << wr_size_q);
            end
        end
    end

    // byte merge under the strobe
    always_ff @(posedge aclk) begin
        if (w_hs) begin
            for (int b = 0; b < 4; b++) begin
                if (axi_w_strb_i[b]) begin
                    mem[wr_idx][8*b +: 8] <= axi_w_data_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: design/cpu_mem_subsys.sv
`timescale 1ns/1ps

module cpu_mem_subsys #(
    parameter int MEM_DEPTH_WORDS = 1024
) (
    input  logic           aclk,
    input  logic           areset_n,
    input  logic           ifu_r_valid_i,
    input  axi_pkg::addr_t ifu_r_addr_i,
    input  axi_pkg::len_t  ifu_r_len_i,
    output logic           ifu_r_ready_o,
    output axi_pkg::data_t ifu_r_data_o,
    output logic           ifu_r_last_o,
    input  logic           lsu_r_valid_i,
    input  axi_pkg::addr_t lsu_r_addr_i,
    input  axi_pkg::len_t  lsu_r_len_i,
    output logic           lsu_r_ready_o,
    output axi_pkg::data_t lsu_r_data_o,
    output logic           lsu_r_last_o,
    input  logic           lsu_w_valid_i,
    input  axi_pkg::addr_t lsu_w_addr_i,
    input  axi_pkg::data_t lsu_w_data_i,
    input  axi_pkg::size_t lsu_w_size_i,
    input  axi_pkg::len_t  lsu_w_len_i,
    output logic           lsu_w_ready_o,
    output logic           lsu_w_last_o
);
    import axi_pkg::*;

    // arbiter to bridge
    logic   cpu_r_valid, cpu_r_ready, cpu_r_last;
    addr_t  cpu_r_addr;
    len_t   cpu_r_len;
    data_t  cpu_r_data;
    logic   cpu_w_valid, cpu_w_ready, cpu_w_last;
    addr_t  cpu_w_addr;
    data_t  cpu_w_data;
    size_t  cpu_w_size;
    len_t   cpu_w_len;

    // bridge to sram
    logic   ar_valid, ar_ready, r_ready, r_valid, r_last;
    addr_t  ar_addr;
    len_t   ar_len;
    size_t  ar_size;
    burst_t ar_burst;
    data_t  r_data;
    logic   aw_valid, aw_ready, w_valid, w_ready, w_last, b_ready, b_valid;
    addr_t  aw_addr;
    len_t   aw_len;
    size_t  aw_size;
    burst_t aw_burst;
    data_t  w_data;
    strb_t  w_strb;

    mem_arbiter i_arbiter (
        .aclk, .areset_n,
        .ifu_r_valid_i, .ifu_r_addr_i, .ifu_r_len_i,
        .ifu_r_ready_o, .ifu_r_data_o, .ifu_r_last_o,
        .lsu_r_valid_i, .lsu_r_addr_i, .lsu_r_len_i,
        .lsu_r_ready_o, .lsu_r_data_o, .lsu_r_last_o,
        .lsu_w_valid_i, .lsu_w_addr_i, .lsu_w_data_i, .lsu_w_size_i, .lsu_w_len_i,
        .lsu_w_ready_o, .lsu_w_last_o,
        .cpu_r_valid_o (cpu_r_valid), .cpu_r_addr_o (cpu_r_addr), .cpu_r_len_o (cpu_r_len),
        .cpu_w_valid_o (cpu_w_valid), .cpu_w_addr_o (cpu_w_addr),
        .cpu_w_data_o  (cpu_w_data),  .cpu_w_size_o (cpu_w_size), .cpu_w_len_o (cpu_w_len),
        .cpu_r_ready_i (cpu_r_ready), .cpu_r_data_i (cpu_r_data), .cpu_r_last_i (cpu_r_last),
        .cpu_w_ready_i (cpu_w_ready), .cpu_w_last_i (cpu_w_last)
    );

    axi_master_bridge i_bridge (
        .aclk, .areset_n,
        .cpu_r_valid_i (cpu_r_valid), .cpu_r_addr_i (cpu_r_addr), .cpu_r_len_i (cpu_r_len),
        .cpu_r_ready_o (cpu_r_ready), .cpu_r_data_o (cpu_r_data), .cpu_r_last_o (cpu_r_last),
        .cpu_w_valid_i (cpu_w_valid), .cpu_w_addr_i (cpu_w_addr), .cpu_w_data_i (cpu_w_data),
        .cpu_w_size_i  (cpu_w_size),  .cpu_w_len_i  (cpu_w_len),
        .cpu_w_ready_o (cpu_w_ready), .cpu_w_last_o (cpu_w_last),
        .axi_ar_valid_o (ar_valid), .axi_ar_addr_o (ar_addr), .axi_ar_len_o (ar_len),
        .axi_ar_size_o  (ar_size),  .axi_ar_burst_o (ar_burst), .axi_ar_ready_i (ar_ready),
        .axi_r_ready_o  (r_ready),  .axi_r_valid_i (r_valid), .axi_r_data_i (r_data),
        .axi_r_last_i   (r_last),
        .axi_aw_valid_o (aw_valid), .axi_aw_addr_o (aw_addr), .axi_aw_len_o (aw_len),
        .axi_aw_size_o  (aw_size),  .axi_aw_burst_o (aw_burst), .axi_aw_ready_i (aw_ready),
        .axi_w_valid_o  (w_valid),  .axi_w_data_o (w_data), .axi_w_strb_o (w_strb),
        .axi_w_last_o   (w_last),   .axi_w_ready_i (w_ready),
        .axi_b_ready_o  (b_ready),  .axi_b_valid_i (b_valid)
    );

    axi_sram_slave #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
    ) i_sram (
        .aclk, .areset_n,
        .axi_ar_valid_i (ar_valid), .axi_ar_addr_i (ar_addr), .axi_ar_len_i (ar_len),
        .axi_ar_size_i  (ar_size),  .axi_ar_burst_i (ar_burst), .axi_ar_ready_o (ar_ready),
        .axi_r_ready_i  (r_ready),  .axi_r_valid_o (r_valid), .axi_r_data_o (r_data),
        .axi_r_last_o   (r_last),
        .axi_aw_valid_i (aw_valid), .axi_aw_addr_i (aw_addr), .axi_aw_len_i (aw_len),
        .axi_aw_size_i  (aw_size),  .axi_aw_burst_i (aw_burst), .axi_aw_ready_o (aw_ready),
        .axi_w_valid_i  (w_valid),  .axi_w_data_i (w_data), .axi_w_strb_i (w_strb),
        .axi_w_last_i   (w_last),   .axi_w_ready_o (w_ready),
        .axi_b_ready_i  (b_ready),  .axi_b_valid_o (b_valid)
    );

endmodule

// File: test/tb_cpu_mem_subsys.sv
`timescale 1ns/1ps

module tb_cpu_mem_subsys;
    import axi_pkg::*;

    localparam int MEM_DEPTH_WORDS = 1024;
    localparam int TIMEOUT_CYCLES  = 200;
    localparam int SEED            = 82;

    logic  aclk;
    logic  areset_n;
    logic  ifu_r_valid_i;
    addr_t ifu_r_addr_i;
    len_t  ifu_r_len_i;
    logic  ifu_r_ready_o;
    data_t ifu_r_data_o;
    logic  ifu_r_last_o;
    logic  lsu_r_valid_i;
    addr_t lsu_r_addr_i;
    len_t  lsu_r_len_i;
    logic  lsu_r_ready_o;
    data_t lsu_r_data_o;
    logic  lsu_r_last_o;
    logic  lsu_w_valid_i;
    addr_t lsu_w_addr_i;
    data_t lsu_w_data_i;
    size_t lsu_w_size_i;
    len_t  lsu_w_len_i;
    logic  lsu_w_ready_o;
    logic  lsu_w_last_o;

    // shadow copy of the sram
    data_t shadow [MEM_DEPTH_WORDS];
    data_t burst_buf [256];
    int    check_count;
    int    err_count;
    int    w_last_pulses;
    logic  monitor_on;

    cpu_mem_subsys #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
    ) i_dut (
        .aclk, .areset_n,
        .ifu_r_valid_i, .ifu_r_addr_i, .ifu_r_len_i,
        .ifu_r_ready_o, .ifu_r_data_o, .ifu_r_last_o,
        .lsu_r_valid_i, .lsu_r_addr_i, .lsu_r_len_i,
        .lsu_r_ready_o, .lsu_r_data_o, .lsu_r_last_o,
        .lsu_w_valid_i, .lsu_w_addr_i, .lsu_w_data_i, .lsu_w_size_i, .lsu_w_len_i,
        .lsu_w_ready_o, .lsu_w_last_o
    );

    always #4 aclk = ~aclk;

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("MISMATCH time %0t: %s, expected %h got %h", $time, what, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        err_count++;
        $display("ERROR time %0t: %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
        finish_run();
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors so far", name, err_count);
    endtask

    // sram word index wraps at the depth
    function automatic int word_of(addr_t a, int beat);
        return int'(((a >> 2) + addr_t'(beat)) % addr_t'(MEM_DEPTH_WORDS));
    endfunction

    // lanes from the byte offset up to the access width
    function automatic strb_t lane_strobe(size_t size, addr_t a);
        strb_t s;
        int    bytes;
        int    first;
        bytes = 1 << int'(size);
        if (bytes > 4) begin
            bytes = 4;
        end
        first = int'(a[1:0]) - (int'(a[1:0]) % bytes);
        s = '0;
        for (int b = 0; b < 4; b++) begin
            s[b] = (b >= first) && (b < first + bytes);
        end
        return s;
    endfunction

    function automatic data_t fill_pattern(int word);
        addr_t a;
        a = addr_t'(word) << 2;
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    // random upper bits exercise the address wrap
    function automatic addr_t make_addr(int word, logic [1:0] low);
        addr_t upper;
        upper = addr_t'($urandom()) & ~addr_t'(MEM_DEPTH_WORDS * 4 - 1);
        return upper | (addr_t'(word) << 2) | addr_t'(low);
    endfunction

    task automatic apply_write(input addr_t addr, input size_t size, input len_t len);
        strb_t strb;
        int    w;
        strb = lane_strobe(size, addr);
        for (int beat = 0; beat <= int'(len); beat++) begin
            w = word_of(addr, beat);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[w][8*b +: 8] = burst_buf[beat][8*b +: 8];
                end
            end
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        compare_value({"ifu ready ", phase}, 32'd0, 32'(ifu_r_ready_o));
        compare_value({"ifu last ", phase}, 32'd0, 32'(ifu_r_last_o));
        compare_value({"lsu read ready ", phase}, 32'd0, 32'(lsu_r_ready_o));
        compare_value({"lsu read last ", phase}, 32'd0, 32'(lsu_r_last_o));
        compare_value({"lsu write ready ", phase}, 32'd0, 32'(lsu_w_ready_o));
        compare_value({"lsu write last ", phase}, 32'd0, 32'(lsu_w_last_o));
    endtask

    // one beat of burst_buf per accepted handshake
    task automatic lsu_write(input addr_t addr, input size_t size, input len_t len);
        int   beat;
        int   accepted;
        int   waited;
        int   pulses_before;
        logic took;
        logic done;
        beat = 0;
        accepted = 0;
        waited = 0;
        took = 1'b0;
        done = 1'b0;
        pulses_before = w_last_pulses;
        @(negedge aclk);
        lsu_w_valid_i = 1'b1;
        lsu_w_addr_i  = addr;
        lsu_w_size_i  = size;
        lsu_w_len_i   = len;
        lsu_w_data_i  = burst_buf[0];
        while (!done && waited < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            waited++;
            // ready seen last cycle means that beat went at the rising edge
            if (took) begin
                beat++;
                if (beat <= int'(len)) begin
                    lsu_w_data_i = burst_buf[beat];
                end
            end
            took = lsu_w_ready_o;
            if (took) begin
                accepted++;
            end
            done = lsu_w_last_o;
        end
        if (done) begin
            compare_value("lsu write beats accepted", 32'(int'(len) + 1), 32'(accepted));
            @(negedge aclk);
            lsu_w_valid_i = 1'b0;
            // a response held a second cycle has been counted by now
            @(posedge aclk);
            compare_value("lsu write response pulses", 32'd1, 32'(w_last_pulses - pulses_before));
            apply_write(addr, size, len);
        end else begin
            report_timeout("lsu write port never returned a write response");
        end
    endtask

    task automatic cpu_read(input bit from_lsu, input addr_t addr, input len_t len,
                            output time first_t, output time last_t);
        string port;
        int    beat;
        int    waited;
        logic  done;
        logic  ready;
        logic  last;
        data_t got;
        port = from_lsu ? "lsu" : "ifu";
        beat = 0;
        waited = 0;
        done = 1'b0;
        first_t = 0;
        last_t = 0;
        @(negedge aclk);
        if (from_lsu) begin
            lsu_r_valid_i = 1'b1;
            lsu_r_addr_i  = addr;
            lsu_r_len_i   = len;
        end else begin
            ifu_r_valid_i = 1'b1;
            ifu_r_addr_i  = addr;
            ifu_r_len_i   = len;
        end
        while (!done && waited < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            waited++;
            ready = from_lsu ? lsu_r_ready_o : ifu_r_ready_o;
            last  = from_lsu ? lsu_r_last_o : ifu_r_last_o;
            got   = from_lsu ? lsu_r_data_o : ifu_r_data_o;
            if (ready) begin
                if (beat == 0) begin
                    first_t = $time;
                end
                compare_value($sformatf("%s read data beat %0d", port, beat),
                              shadow[word_of(addr, beat)], got);
                compare_value($sformatf("%s read last on beat %0d", port, beat),
                              32'(beat == int'(len)), 32'(last));
                beat++;
                if (last) begin
                    done = 1'b1;
                    last_t = $time;
                end
            end
        end
        if (done) begin
            compare_value($sformatf("%s read beat count", port), 32'(int'(len) + 1), 32'(beat));
            @(negedge aclk);
            if (from_lsu) begin
                lsu_r_valid_i = 1'b0;
            end else begin
                ifu_r_valid_i = 1'b0;
            end
        end else begin
            report_timeout($sformatf("%s read port never returned its last beat", port));
        end
    endtask

    task automatic wait_ifu_beat();
        int   waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            waited++;
            seen = ifu_r_ready_o;
        end
        if (!seen) begin
            report_timeout("ifu read port never returned a first beat");
        end
    endtask

    task automatic random_reads(input bit from_lsu, input int base);
        int   word;
        len_t len;
        time  t_first;
        time  t_last;
        for (int i = 0; i < 4; i++) begin
            repeat ($urandom_range(0, 3)) @(negedge aclk);
            word = base + int'($urandom_range(0, MEM_DEPTH_WORDS / 2 - 8));
            len  = len_t'($urandom_range(0, 7));
            cpu_read(from_lsu, make_addr(word, 2'b00), len, t_first, t_last);
        end
    endtask

    task automatic random_writes(input int base);
        int         word;
        size_t      size;
        len_t       len;
        logic [1:0] low;
        for (int i = 0; i < 4; i++) begin
            word = base + int'($urandom_range(0, MEM_DEPTH_WORDS / 2 - 8));
            size = size_t'($urandom_range(0, 2));
            len  = (size == SIZE_4) ? len_t'($urandom_range(0, 7)) : 8'd0;
            low  = (size == SIZE_1) ? 2'($urandom_range(0, 3)) :
                   (size == SIZE_2) ? {1'($urandom_range(0, 1)), 1'b0} : 2'b00;
            for (int b = 0; b <= int'(len); b++) begin
                burst_buf[b] = $urandom();
            end
            lsu_write(make_addr(word, low), size, len);
        end
    endtask

    // write response pulses counted mid cycle
    always @(negedge aclk) begin
        if (lsu_w_last_o) begin
            w_last_pulses++;
        end
    end

    // read port isolation checked on the rising edge once the requests have settled
    always @(posedge aclk) begin
        if (monitor_on) begin
            compare_value("ifu ready without an ifu request", 32'd0,
                          32'(ifu_r_ready_o && !ifu_r_valid_i));
            compare_value("lsu ready without an lsu request", 32'd0,
                          32'(lsu_r_ready_o && !lsu_r_valid_i));
            compare_value("both read ports ready together", 32'd0,
                          32'(ifu_r_ready_o && lsu_r_ready_o));
        end
    end

    initial begin
        int         word;
        size_t      size;
        len_t       len;
        logic [1:0] low;
        addr_t      addr;
        addr_t      a_ifu;
        addr_t      a_lsu;
        time        ifu_first;
        time        ifu_last;
        time        lsu_first;
        time        lsu_last;
        int         rd_base;
        aclk = 1'b0;
        areset_n = 1'b1;
        ifu_r_valid_i = 1'b0;
        ifu_r_addr_i = '0;
        ifu_r_len_i = '0;
        lsu_r_valid_i = 1'b0;
        lsu_r_addr_i = '0;
        lsu_r_len_i = '0;
        lsu_w_valid_i = 1'b0;
        lsu_w_addr_i = '0;
        lsu_w_data_i = '0;
        lsu_w_size_i = '0;
        lsu_w_len_i = '0;
        check_count = 0;
        err_count = 0;
        w_last_pulses = 0;
        monitor_on = 1'b0;
        void'($urandom(SEED));

        repeat (10) begin
            @(negedge aclk);
            check_idle_outputs("during reset");
        end
        areset_n = 1'b0;
        repeat (3) begin
            @(negedge aclk);
            check_idle_outputs("after reset");
        end
        end_test("reset");
        monitor_on = 1'b1;

        // the sram powers up unknown so every word gets a known value first
        for (int w = 0; w < MEM_DEPTH_WORDS; w += 8) begin
            for (int b = 0; b < 8; b++) begin
                burst_buf[b] = fill_pattern(w + b);
            end
            lsu_write(make_addr(w, 2'b00), SIZE_4, 8'd7);
        end
        end_test("preload");

        repeat (40) begin
            word = int'($urandom_range(0, MEM_DEPTH_WORDS - 1));
            size = size_t'($urandom_range(0, 2));
            low  = (size == SIZE_1) ? 2'($urandom_range(0, 3)) :
                   (size == SIZE_2) ? {1'($urandom_range(0, 1)), 1'b0} : 2'b00;
            addr = make_addr(word, low);
            burst_buf[0] = $urandom();
            lsu_write(addr, size, 8'd0);
            cpu_read(1'b1, addr & ~addr_t'(3), 8'd0, lsu_first, lsu_last);
        end
        end_test("write_readback");

        repeat (20) begin
            word = int'($urandom_range(0, MEM_DEPTH_WORDS - 1));
            len  = len_t'($urandom_range(0, 7));
            for (int b = 0; b <= int'(len); b++) begin
                burst_buf[b] = $urandom();
            end
            addr = make_addr(word, 2'b00);
            lsu_write(addr, SIZE_4, len);
            cpu_read(1'b0, addr, len, ifu_first, ifu_last);
        end
        end_test("bursts");

        a_ifu = make_addr(int'($urandom_range(0, MEM_DEPTH_WORDS - 1)), 2'b00);
        a_lsu = make_addr(int'($urandom_range(0, MEM_DEPTH_WORDS - 1)), 2'b00);
        // same edge request where lsu goes first
        fork
            cpu_read(1'b0, a_ifu, 8'd7, ifu_first, ifu_last);
            cpu_read(1'b1, a_lsu, 8'd3, lsu_first, lsu_last);
        join
        compare_value("lsu last before the first ifu beat", 32'd1,
                      32'(lsu_last < ifu_first));
        // lsu arrives mid burst and waits
        fork
            cpu_read(1'b0, a_ifu, 8'd7, ifu_first, ifu_last);
            begin
                wait_ifu_beat();
                cpu_read(1'b1, a_lsu, 8'd0, lsu_first, lsu_last);
            end
        join
        compare_value("ifu burst done before the lsu beat", 32'd1,
                      32'(ifu_last < lsu_first));
        end_test("priority");

        // reads and writes use opposite halves that swap each round
        for (int round = 0; round < 8; round++) begin
            rd_base = (round % 2) * (MEM_DEPTH_WORDS / 2);
            fork
                random_reads(1'b0, rd_base);
                random_reads(1'b1, rd_base);
                random_writes(MEM_DEPTH_WORDS / 2 - rd_base);
            join
        end
        end_test("random_mix");

        finish_run();
    end

endmodule

// File: list.f
design/axi_pkg.sv
design/mem_arbiter.sv
design/axi_master_bridge.sv
design/axi_sram_slave.sv
design/cpu_mem_subsys.sv
test/tb_cpu_mem_subsys.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
    && verilator --binary --timing -Wno-fatal --top-module tb_cpu_mem_subsys \
        -f list.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && grep -q "TESTS PASSED" sim.log \
    && echo "simulation ok" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
